// File: Bender.yml
package:
  name: hub75_panel

sources:
  # package first, then the leaf modules, then the top level
  - files:
      - rtl/hub75_pkg.sv
      - rtl/column_countdown.sv
      - rtl/pixel_shift_clocker.sv
      - rtl/pixel_frame_buffer.sv
      - rtl/row_scanner.sv
      - rtl/hub75_top.sv

  - target: simulation
    files:
      - verification/hub75_tb.sv

// File: filelist.f
rtl/hub75_pkg.sv
rtl/column_countdown.sv
rtl/pixel_shift_clocker.sv
rtl/pixel_frame_buffer.sv
rtl/row_scanner.sv
rtl/hub75_top.sv
verification/hub75_tb.sv

// File: rtl/column_countdown.sv
`default_nettype none

module column_countdown (
  input  logic              clk,
  input  logic              rst,
  input  logic              load,
  input  logic              dec,
  output hub75_pkg::count_t remaining
);
  import hub75_pkg::*;

  count_t count;

  // load wins over dec so a fresh burst always starts from the full width
  always_ff @(posedge clk) begin
    if (rst || load) begin
      count <= count_t'(PANEL_WIDTH);
    end else if (dec && (count != '0)) begin
      count <= count - 1'b1;   // stops at zero instead of wrapping
    end
  end

  assign remaining = count;

endmodule

`default_nettype wire

// File: rtl/hub75_pkg.sv
`default_nettype none

package hub75_pkg;

  // panel geometry for a 64 x 32 panel driven at 1/16 scan
  localparam int PANEL_WIDTH = 64;
  localparam int PANEL_ROWS  = 16;

  localparam int COL_W = 6;
  localparam int ROW_W = 4;
  localparam int Y_W   = 5;   // host rows 0 to 31 span both halves

  // one more bit than COL_W so the countdown can hold PANEL_WIDTH itself
  localparam int COUNT_W = 7;

  // clk cycles a latched row stays lit
  localparam int DISPLAY_CYCLES = 256;
  localparam int DISP_W         = $clog2(DISPLAY_CYCLES);

  typedef logic [COL_W-1:0] col_t;

  typedef logic [ROW_W-1:0] row_t;

  typedef logic [Y_W-1:0] ypos_t;

  // bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] rgb_t;

  typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// File: rtl/hub75_top.sv
`default_nettype none

module hub75_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,
  input  logic             wr_en,
  input  hub75_pkg::col_t  wr_x,
  input  hub75_pkg::ypos_t wr_y,
  input  hub75_pkg::rgb_t  wr_rgb,
  output logic             r0,
  output logic             g0,
  output logic             b0,
  output logic             r1,
  output logic             g1,
  output logic             b1,
  output logic             sclk,
  output logic             lat,
  output logic             oe_n,
  output hub75_pkg::row_t  row_addr
);
  import hub75_pkg::*;

  col_t col;
  row_t shift_row;
  rgb_t upper_rgb;
  rgb_t lower_rgb;
  logic shift_init;
  logic finish;

  pixel_frame_buffer u_frame_buffer (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_x      (wr_x),
    .wr_y      (wr_y),
    .wr_rgb    (wr_rgb),
    .rd_row    (shift_row),
    .rd_col    (col),
    .upper_rgb (upper_rgb),
    .lower_rgb (lower_rgb)
  );

  pixel_shift_clocker u_clocker (
    .clk          (clk),
    .rst          (rst),
    .init         (shift_init),
    .shift_active (),
    .finish       (finish),
    .sclk         (sclk),
    .col          (col)
  );

  row_scanner u_scanner (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .finish     (finish),
    .shift_init (shift_init),
    .lat        (lat),
    .oe_n       (oe_n),
    .shift_row  (shift_row),
    .row_addr   (row_addr)
  );

  // upper half of the panel on the 0 pins, lower half on the 1 pins
  assign r0 = upper_rgb[2];
  assign g0 = upper_rgb[1];
  assign b0 = upper_rgb[0];
  assign r1 = lower_rgb[2];
  assign g1 = lower_rgb[1];
  assign b1 = lower_rgb[0];

endmodule

`default_nettype wire

// File: rtl/pixel_frame_buffer.sv
`default_nettype none

module pixel_frame_buffer (
  input  logic             clk,
  input  logic             wr_en,
  input  hub75_pkg::col_t  wr_x,
  input  hub75_pkg::ypos_t wr_y,
  input  hub75_pkg::rgb_t  wr_rgb,
  input  hub75_pkg::row_t  rd_row,
  input  hub75_pkg::col_t  rd_col,
  output hub75_pkg::rgb_t  upper_rgb,
  output hub75_pkg::rgb_t  lower_rgb
);
  import hub75_pkg::*;

  // upper bank holds panel rows 0 to 15, lower bank rows 16 to 31
  rgb_t upper_mem [PANEL_ROWS][PANEL_WIDTH];
  rgb_t lower_mem [PANEL_ROWS][PANEL_WIDTH];

  row_t wr_row;
  logic wr_lower;

  assign wr_row   = wr_y[ROW_W-1:0];
  assign wr_lower = wr_y[Y_W-1];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (wr_lower) begin
        lower_mem[wr_row][wr_x] <= wr_rgb;
      end else begin
        upper_mem[wr_row][wr_x] <= wr_rgb;
      end
    end
  end

  // the panel shifts row r and row r+16 together, so both banks share one address
  assign upper_rgb = upper_mem[rd_row][rd_col];
  assign lower_rgb = lower_mem[rd_row][rd_col];

endmodule

`default_nettype wire

// File: rtl/pixel_shift_clocker.sv
`default_nettype none

module pixel_shift_clocker (
  input  logic            clk,
  input  logic            rst,
  input  logic            init,
  output logic            shift_active,
  output logic            finish,
  output logic            sclk,
  output hub75_pkg::col_t col
);
  import hub75_pkg::*;

  enum logic [1:0] {
    ST_START,
    ST_ITERATE,
    ST_FINISH
  } state;

  logic   cd_load;
  logic   cd_dec;
  count_t cd_remaining;
  count_t col_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_START;
      shift_active <= 1'b0;
      finish       <= 1'b0;
    end else begin
      case (state)
        ST_START: begin
          if (init) begin
            state        <= ST_ITERATE;
            shift_active <= 1'b1;
          end
        end
        ST_ITERATE: begin
          // the last column is being shifted when one remains
          if (cd_remaining == count_t'(1)) begin
            state        <= ST_FINISH;
            shift_active <= 1'b0;
            finish       <= 1'b1;
          end
        end
        ST_FINISH: begin
          if (init) begin   // a new burst can start straight from here
            state        <= ST_ITERATE;
            shift_active <= 1'b1;
            finish       <= 1'b0;
          end
        end
        default: begin
          state        <= ST_START;
          shift_active <= 1'b0;
          finish       <= 1'b0;
        end
      endcase
    end
  end

  // reload in finish as well, so the count is full again before the next init
  assign cd_load = (state != ST_ITERATE);
  assign cd_dec  = shift_active;

  column_countdown u_countdown (
    .clk       (clk),
    .rst       (rst),
    .load      (cd_load),
    .dec       (cd_dec),
    .remaining (cd_remaining)
  );

  assign col_count = count_t'(PANEL_WIDTH) - cd_remaining;
  assign col       = col_count[COL_W-1:0];

  // sclk rises at the falling clk edge, mid-way through each data cycle
  assign sclk = shift_active & ~clk;

endmodule

`default_nettype wire

// File: rtl/row_scanner.sv
`default_nettype none

module row_scanner (
  input  logic            clk,
  input  logic            rst,
  input  logic            enable,
  input  logic            finish,
  output logic            shift_init,
  output logic            lat,
  output logic            oe_n,
  output hub75_pkg::row_t shift_row,
  output hub75_pkg::row_t row_addr
);
  import hub75_pkg::*;

  enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_LATCH,
    ST_DISPLAY
  } state;

  logic [DISP_W-1:0] disp_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      shift_init <= 1'b0;
      lat        <= 1'b0;
      oe_n       <= 1'b1;
      shift_row  <= '0;
      row_addr   <= '0;
      disp_count <= '0;
    end else begin
      shift_init <= 1'b0;   // init and lat are single-cycle strobes
      lat        <= 1'b0;
      case (state)
        ST_IDLE: begin
          // enable is only looked at here, so a row in progress always completes
          oe_n <= 1'b1;
          if (enable) begin
            shift_init <= 1'b1;
            state      <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          // finish from the last burst is still high while init is out
          if (finish && !shift_init) begin
            lat      <= 1'b1;
            row_addr <= shift_row;
            state    <= ST_LATCH;
          end
        end
        ST_LATCH: begin
          oe_n       <= 1'b0;
          disp_count <= DISP_W'(DISPLAY_CYCLES - 1);
          state      <= ST_DISPLAY;
        end
        ST_DISPLAY: begin
          if (disp_count == '0) begin
            oe_n      <= 1'b1;
            shift_row <= shift_row + 1'b1;   // wraps 15 to 0
            state     <= ST_IDLE;
          end else begin
            disp_count <= disp_count - 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
          oe_n  <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verification/hub75_tb.sv
`default_nettype none

module hub75_tb;
  import hub75_pkg::*;

  localparam int ROW_TIMEOUT = 1000;   // one row takes about 330 clk cycles
  localparam int IDLE_WINDOW = 400;
  localparam int REWRITE_X   = 17;
  localparam int REWRITE_Y   = 21;

  logic  clk;
  logic  rst;
  logic  enable;
  logic  wr_en;
  col_t  wr_x;
  ypos_t wr_y;
  rgb_t  wr_rgb;
  logic  r0;
  logic  g0;
  logic  b0;
  logic  r1;
  logic  g1;
  logic  b1;
  logic  sclk;
  logic  lat;
  logic  oe_n;
  row_t  row_addr;

  // expected pixels indexed [y][x], y 0 to 31 as the host sees it
  rgb_t   model [2*PANEL_ROWS][PANEL_WIDTH];
  rgb_t   cap_lower [PANEL_ROWS][PANEL_WIDTH];
  integer seed;
  int     mismatches;
  int     timeouts;
  int     sclk_edges;
  int     sclk_total;
  int     lat_total;
  int     low_cycles;
  row_t   mon_row;
  logic   prev_lat;

  hub75_top DUT (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .wr_en    (wr_en),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_rgb   (wr_rgb),
    .r0       (r0),
    .g0       (g0),
    .b0       (b0),
    .r1       (r1),
    .g1       (g1),
    .b1       (b1),
    .sclk     (sclk),
    .lat      (lat),
    .oe_n     (oe_n),
    .row_addr (row_addr)
  );

  always #50 clk = ~clk;

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatches++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run;
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: the DUT gave no %s within the cycle limit", what);
    finish_run;
  endtask

  task automatic wait_for_lat(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    while (lat !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (lat !== 1'b1) report_timeout("lat pulse");
  endtask

  task automatic wait_for_oe(input logic level, input int limit);
    int n;
    n = 0;
    @(posedge clk);
    while (oe_n !== level && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (oe_n !== level) report_timeout("change of oe_n");
  endtask

  // the DUT takes the pixel on the second edge, which is when the model follows
  task automatic write_pixel(input col_t x, input ypos_t y, input rgb_t rgb);
    @(posedge clk);
    wr_en  <= 1'b1;
    wr_x   <= x;
    wr_y   <= y;
    wr_rgb <= rgb;
    @(posedge clk);
    wr_en <= 1'b0;
    model[y][x] = rgb;
  endtask

  // panel side monitor, one column per sclk rising edge
  always @(posedge sclk) begin
    if (sclk_edges < PANEL_WIDTH) begin
      cap_lower[mon_row][sclk_edges] = {r1, g1, b1};
      check_rgb($sformatf("upper rgb row %0d col %0d", mon_row, sclk_edges),
                {r0, g0, b0}, model[mon_row][sclk_edges]);
      check_rgb($sformatf("lower rgb row %0d col %0d", mon_row, sclk_edges),
                {r1, g1, b1}, model[int'(mon_row) + PANEL_ROWS][sclk_edges]);
    end
    sclk_edges++;
    sclk_total++;
  end

  always @(posedge clk) begin
    if (rst) begin
      sclk_edges = 0;
      sclk_total = 0;
      lat_total  = 0;
      low_cycles = 0;
      mon_row    = '0;
      prev_lat   = 1'b0;
    end else begin
      if (prev_lat) check_bit("lat width", lat, 1'b0);
      if (lat === 1'b1 && !prev_lat) begin
        check_count("sclk edges per row", sclk_edges, PANEL_WIDTH);
        check_bit("oe_n at latch", oe_n, 1'b1);
        // the first latch has no display window before it
        if (lat_total > 0) check_count("oe_n low cycles", low_cycles, DISPLAY_CYCLES);
        sclk_edges = 0;
        low_cycles = 0;
        lat_total++;
        mon_row = mon_row + 1'b1;
      end
      if (oe_n === 1'b0) low_cycles++;
      prev_lat = lat;
    end
  end

  task automatic test_reset_state;
    repeat (20) begin
      @(posedge clk);
      check_bit("lat", lat, 1'b0);
      check_bit("oe_n", oe_n, 1'b1);
      check_row("row_addr", row_addr, '0);
    end
    check_count("sclk edges while idle", sclk_total, 0);
  endtask

  task automatic fill_random_pixels;
    int v;
    seed = 32'h3cfa;
    for (int y = 0; y < 2*PANEL_ROWS; y++) begin
      for (int x = 0; x < PANEL_WIDTH; x++) begin
        v = $random(seed);
        write_pixel(col_t'(x), ypos_t'(y), rgb_t'(v));
      end
    end
  endtask

  // a full frame plus one row, so the wrap from 15 to 0 is seen
  task automatic test_scan_frame;
    @(posedge clk);
    enable <= 1'b1;
    for (int i = 0; i <= PANEL_ROWS; i++) begin
      wait_for_lat(ROW_TIMEOUT);
      check_row("row_addr", row_addr, row_t'(i));
    end
  endtask

  task automatic test_rewrite;
    rgb_t new_rgb;
    row_t target;
    int   n;
    target = row_t'(REWRITE_Y - PANEL_ROWS);
    wait_for_lat(ROW_TIMEOUT);   // the write lands in a display window
    new_rgb = ~model[REWRITE_Y][REWRITE_X];
    write_pixel(col_t'(REWRITE_X), ypos_t'(REWRITE_Y), new_rgb);
    wait_for_lat(ROW_TIMEOUT);
    n = 1;
    while (row_addr !== target && n <= PANEL_ROWS) begin
      wait_for_lat(ROW_TIMEOUT);
      n++;
    end
    if (row_addr !== target) report_timeout("burst of the rewritten row");
    check_rgb("rewritten lower rgb", cap_lower[target][REWRITE_X], new_rgb);
  endtask

  task automatic test_stop;
    int lats_before;
    int edges_before;
    wait_for_lat(ROW_TIMEOUT);
    enable <= 1'b0;
    wait_for_oe(1'b0, 10);
    wait_for_oe(1'b1, DISPLAY_CYCLES + 10);
    lats_before  = lat_total;
    edges_before = sclk_total;
    repeat (IDLE_WINDOW) begin
      @(posedge clk);
      check_bit("oe_n after stop", oe_n, 1'b1);
    end
    check_count("lat pulses after stop", lat_total - lats_before, 0);
    check_count("sclk edges after stop", sclk_total - edges_before, 0);
    check_count("oe_n low cycles of last row", low_cycles, DISPLAY_CYCLES);
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    enable     = 1'b0;
    wr_en      = 1'b0;
    wr_x       = '0;
    wr_y       = '0;
    wr_rgb     = '0;
    mismatches = 0;
    timeouts   = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_reset_state;
    fill_random_pixels;
    test_scan_frame;
    test_rewrite;
    test_stop;
    finish_run;
  end

endmodule

`default_nettype wire
